//--- cpu_params_pkg.sv
// rv64 data widths and register-file sizes, imported by every pipeline module
package cpu_params_pkg;

  // data path
  localparam int WORD_WD     = 64;  // xlen
  localparam int OFFSET_WD   = 3;   // byte lane within one sram word

  // register files
  localparam int GPR_ADDR_WD = 5;
  localparam int NUM_GPR     = 32;
  localparam int CSR_ADDR_WD = 12;  // full csr address space

endpackage

//--- mem_types_pkg.sv
// load op codes and read-word views, imported by the memory stage and load formatter
package mem_types_pkg;

  import cpu_params_pkg::*;

  // lane widths inside one read word
  localparam int BYTE_WD  = 8;
  localparam int HALF_WD  = 16;
  localparam int SWORD_WD = 32;

  // funct3 of the rv64 load group
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110
  } mem_op_e;

  // one sram read word seen as byte, half, word or full lanes
  typedef union packed {
    logic [WORD_WD/BYTE_WD-1:0][BYTE_WD-1:0]   byte_lane;
    logic [WORD_WD/HALF_WD-1:0][HALF_WD-1:0]   half_lane;
    logic [WORD_WD/SWORD_WD-1:0][SWORD_WD-1:0] word_lane;
    logic [WORD_WD-1:0]                        dword;
  } sram_word_u;

endpackage

//--- ms_ws_if.sv
`timescale 1ns/1ps
// memory-to-writeback handshake and result bundle, connected between mem_stage and wb_stage
interface ms_ws_if
  import cpu_params_pkg::*;
();

  logic                   ms_to_ws_valid;
  logic                   ws_allowin;

  // result bundle, stable while valid is high
  logic                   gpr_wen;
  logic [GPR_ADDR_WD-1:0] rd;
  logic [WORD_WD-1:0]     gpr_wdata;
  logic                   csr_wen;
  logic [CSR_ADDR_WD-1:0] csr_addr;
  logic [WORD_WD-1:0]     csr_wdata;

  modport ms (
    output ms_to_ws_valid,
    output gpr_wen,
    output rd,
    output gpr_wdata,
    output csr_wen,
    output csr_addr,
    output csr_wdata,
    input  ws_allowin
  );

  modport ws (
    input  ms_to_ws_valid,
    input  gpr_wen,
    input  rd,
    input  gpr_wdata,
    input  csr_wen,
    input  csr_addr,
    input  csr_wdata,
    output ws_allowin
  );

endinterface

//--- lsu_load.sv
`timescale 1ns/1ps
// load formatter: picks the addressed lane of the read word and extends it to 64 bits
module lsu_load
  import cpu_params_pkg::*, mem_types_pkg::*;
(
  input  logic [OFFSET_WD-1:0] i_raddr_offset,  // low bits of x[rs1] + imm
  input  sram_word_u           i_rdata,
  input  mem_op_e              i_mem_op,
  output logic [WORD_WD-1:0]   o_rdata
);

  logic [BYTE_WD-1:0]  byte_sel;
  logic [HALF_WD-1:0]  half_sel;
  logic [SWORD_WD-1:0] word_sel;

  // misaligned offsets drop the low bits below the access size
  assign byte_sel = i_rdata.byte_lane[i_raddr_offset];
  assign half_sel = i_rdata.half_lane[i_raddr_offset[OFFSET_WD-1:1]];
  assign word_sel = i_rdata.word_lane[i_raddr_offset[OFFSET_WD-1]];

  always_comb begin
    case (i_mem_op)
      LB: begin
        o_rdata = {{(WORD_WD-BYTE_WD){byte_sel[BYTE_WD-1]}}, byte_sel};
      end
      LH: begin
        o_rdata = {{(WORD_WD-HALF_WD){half_sel[HALF_WD-1]}}, half_sel};
      end
      LW: begin
        o_rdata = {{(WORD_WD-SWORD_WD){word_sel[SWORD_WD-1]}}, word_sel};
      end
      LBU: begin
        o_rdata = {{(WORD_WD-BYTE_WD){1'b0}}, byte_sel};
      end
      LHU: begin
        o_rdata = {{(WORD_WD-HALF_WD){1'b0}}, half_sel};
      end
      LWU: begin
        o_rdata = {{(WORD_WD-SWORD_WD){1'b0}}, word_sel};
      end
      default: begin
        o_rdata = i_rdata.dword;  // LD and the unused code
      end
    endcase
  end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps
// memory pipeline stage: waits for load data, holds it until writeback takes the instruction
module mem_stage
  import cpu_params_pkg::*, mem_types_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  // from execute
  input  logic                   i_es_to_ms_valid,
  input  logic                   i_es_gpr_wen,
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic                   i_es_csr_wen,
  input  logic [CSR_ADDR_WD-1:0] i_es_csr,
  input  logic                   i_es_mem_ren,
  input  mem_op_e                i_es_mem_op,
  input  logic                   i_es_csr_inst_sel,
  input  logic [WORD_WD-1:0]     i_es_csrrdata,
  input  logic [WORD_WD-1:0]     i_es_alu_result,
  input  logic [WORD_WD-1:0]     i_es_csr_result,
  output logic                   o_ms_allowin,
  // from data sram
  input  logic                   i_data_sram_data_ok,
  input  logic [WORD_WD-1:0]     i_data_sram_rdata,
  // to writeback
  ms_ws_if.ms                    ms,
  // bypass to decode
  output logic [GPR_ADDR_WD-1:0] o_ms_byp_rd,
  output logic [WORD_WD-1:0]     o_ms_byp_gpr_data,
  output logic [CSR_ADDR_WD-1:0] o_ms_byp_csr,
  output logic [WORD_WD-1:0]     o_ms_byp_csr_data,
  output logic                   o_ms_byp_ready
);

  logic                   ms_valid;
  logic                   ms_ready_go;
  logic                   ms_accept;
  logic                   ms_load_done;  // data_ok seen for the current load
  logic                   ms_load_cap;

  logic                   ms_gpr_wen;
  logic [GPR_ADDR_WD-1:0] ms_rd;
  logic                   ms_csr_wen;
  logic [CSR_ADDR_WD-1:0] ms_csr;
  logic                   ms_mem_ren;
  mem_op_e                ms_mem_op;
  logic                   ms_csr_inst_sel;
  logic [WORD_WD-1:0]     ms_csrrdata;
  logic [WORD_WD-1:0]     ms_alu_result;
  logic [WORD_WD-1:0]     ms_csr_result;

  logic [WORD_WD-1:0]     ms_rdata_hold;
  logic [WORD_WD-1:0]     ms_rdata_word;
  logic [WORD_WD-1:0]     ms_load_data;
  logic [WORD_WD-1:0]     ms_gpr_result;

  assign ms_accept    = i_es_to_ms_valid && o_ms_allowin;
  assign ms_ready_go  = !ms_mem_ren || ms_load_done || i_data_sram_data_ok;
  assign o_ms_allowin = !ms_valid || (ms_ready_go && ms.ws_allowin);
  assign ms_load_cap  = ms_valid && ms_mem_ren && !ms_load_done && i_data_sram_data_ok;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_to_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ms_accept) begin
      ms_gpr_wen      <= i_es_gpr_wen;
      ms_rd           <= i_es_rd;
      ms_csr_wen      <= i_es_csr_wen;
      ms_csr          <= i_es_csr;
      ms_mem_ren      <= i_es_mem_ren;
      ms_mem_op       <= i_es_mem_op;
      ms_csr_inst_sel <= i_es_csr_inst_sel;
      ms_csrrdata     <= i_es_csrrdata;
      ms_alu_result   <= i_es_alu_result;
      ms_csr_result   <= i_es_csr_result;
    end
  end

  // the returned word survives writeback back-pressure
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ms_load_done <= 1'b0;
    end else if (ms_accept) begin
      ms_load_done <= 1'b0;
    end else if (ms_load_cap) begin
      ms_load_done <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ms_accept) begin
      ms_rdata_hold <= '0;
    end else if (ms_load_cap) begin
      ms_rdata_hold <= i_data_sram_rdata;
    end
  end

  assign ms_rdata_word = ms_load_done ? ms_rdata_hold : i_data_sram_rdata;

  lsu_load u_lsu_load (
    .i_raddr_offset (ms_alu_result[OFFSET_WD-1:0]),  // x[rs1] + imm
    .i_rdata        (ms_rdata_word),
    .i_mem_op       (ms_mem_op),
    .o_rdata        (ms_load_data)
  );

  assign ms_gpr_result = ms_mem_ren      ? ms_load_data :
                         ms_csr_inst_sel ? ms_csrrdata  : ms_alu_result;

  assign ms.ms_to_ws_valid = ms_valid && ms_ready_go;
  assign ms.gpr_wen        = ms_gpr_wen;
  assign ms.rd             = ms_rd;
  assign ms.gpr_wdata      = ms_gpr_result;
  assign ms.csr_wen        = ms_csr_wen;
  assign ms.csr_addr       = ms_csr;
  assign ms.csr_wdata      = ms_csr_result;

  // zero unless the stage really writes that register
  assign o_ms_byp_rd       = (ms_valid && ms_gpr_wen) ? ms_rd : '0;
  assign o_ms_byp_gpr_data = (ms_valid && ms_gpr_wen) ? ms_gpr_result : '0;
  assign o_ms_byp_csr      = (ms_valid && ms_csr_wen) ? ms_csr : '0;
  assign o_ms_byp_csr_data = (ms_valid && ms_csr_wen) ? ms_csr_result : '0;
  assign o_ms_byp_ready    = ms_valid && ms_gpr_wen && ms_ready_go;

endmodule

//--- wb_stage.sv
`timescale 1ns/1ps
// writeback stage: commits the gpr result into the register file and reports csr writes
module wb_stage
  import cpu_params_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_ws_hold,  // stall from later logic
  // from memory stage
  ms_ws_if.ws                    ws,
  // decode read port
  input  logic [GPR_ADDR_WD-1:0] i_rf_raddr,
  output logic [WORD_WD-1:0]     o_rf_rdata,
  // commit
  output logic                   o_ws_gpr_wen,
  output logic [GPR_ADDR_WD-1:0] o_ws_rd,
  output logic [WORD_WD-1:0]     o_ws_gpr_wdata,
  output logic                   o_ws_csr_wen,
  output logic [CSR_ADDR_WD-1:0] o_ws_csr,
  output logic [WORD_WD-1:0]     o_ws_csr_wdata
);

  logic                   ws_valid;
  logic                   ws_ready_go;
  logic                   ws_commit;

  logic                   ws_gpr_wen;
  logic [GPR_ADDR_WD-1:0] ws_rd;
  logic [WORD_WD-1:0]     ws_gpr_wdata;
  logic                   ws_csr_wen;
  logic [CSR_ADDR_WD-1:0] ws_csr;
  logic [WORD_WD-1:0]     ws_csr_wdata;

  logic [WORD_WD-1:0]     gpr [NUM_GPR];

  assign ws_ready_go   = !i_ws_hold;
  assign ws.ws_allowin = !ws_valid || ws_ready_go;
  assign ws_commit     = ws_valid && ws_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ws_valid <= 1'b0;
    end else if (ws.ws_allowin) begin
      ws_valid <= ws.ms_to_ws_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ws.ms_to_ws_valid && ws.ws_allowin) begin
      ws_gpr_wen   <= ws.gpr_wen;
      ws_rd        <= ws.rd;
      ws_gpr_wdata <= ws.gpr_wdata;
      ws_csr_wen   <= ws.csr_wen;
      ws_csr       <= ws.csr_addr;
      ws_csr_wdata <= ws.csr_wdata;
    end
  end

  // x0 is never written
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        gpr[i] <= '0;
      end
    end else if (o_ws_gpr_wen && (ws_rd != '0)) begin
      gpr[ws_rd] <= ws_gpr_wdata;
    end
  end

  assign o_rf_rdata = (i_rf_raddr == '0) ? '0 : gpr[i_rf_raddr];

  // valid only in the cycle the instruction retires
  assign o_ws_gpr_wen   = ws_commit && ws_gpr_wen;
  assign o_ws_rd        = ws_rd;
  assign o_ws_gpr_wdata = ws_gpr_wdata;
  assign o_ws_csr_wen   = ws_commit && ws_csr_wen;
  assign o_ws_csr       = ws_csr;
  assign o_ws_csr_wdata = ws_csr_wdata;

endmodule

//--- mem_wb_top.sv
`timescale 1ns/1ps
// top of the pipeline back end: memory and writeback stages behind plain ports
module mem_wb_top
  import cpu_params_pkg::*, mem_types_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  // execute side
  input  logic                   i_es_to_ms_valid,
  input  logic                   i_es_gpr_wen,
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic                   i_es_csr_wen,
  input  logic [CSR_ADDR_WD-1:0] i_es_csr,
  input  logic                   i_es_mem_ren,
  input  mem_op_e                i_es_mem_op,
  input  logic                   i_es_csr_inst_sel,
  input  logic [WORD_WD-1:0]     i_es_csrrdata,
  input  logic [WORD_WD-1:0]     i_es_alu_result,
  input  logic [WORD_WD-1:0]     i_es_csr_result,
  output logic                   o_ms_allowin,
  output logic                   o_ms_to_ws_valid,
  // data sram
  input  logic                   i_data_sram_data_ok,
  input  logic [WORD_WD-1:0]     i_data_sram_rdata,
  // decode side
  output logic [GPR_ADDR_WD-1:0] o_ms_byp_rd,
  output logic [WORD_WD-1:0]     o_ms_byp_gpr_data,
  output logic [CSR_ADDR_WD-1:0] o_ms_byp_csr,
  output logic [WORD_WD-1:0]     o_ms_byp_csr_data,
  output logic                   o_ms_byp_ready,
  input  logic [GPR_ADDR_WD-1:0] i_rf_raddr,
  output logic [WORD_WD-1:0]     o_rf_rdata,
  // writeback
  input  logic                   i_ws_hold,
  output logic                   o_ws_gpr_wen,
  output logic [GPR_ADDR_WD-1:0] o_ws_rd,
  output logic [WORD_WD-1:0]     o_ws_gpr_wdata,
  output logic                   o_ws_csr_wen,
  output logic [CSR_ADDR_WD-1:0] o_ws_csr,
  output logic [WORD_WD-1:0]     o_ws_csr_wdata
);

  ms_ws_if u_ms_ws_if ();

  assign o_ms_to_ws_valid = u_ms_ws_if.ms_to_ws_valid;  // end of load latency

  mem_stage u_mem_stage (
    .i_clk               (i_clk),
    .i_rst               (i_rst),
    .i_es_to_ms_valid    (i_es_to_ms_valid),
    .i_es_gpr_wen        (i_es_gpr_wen),
    .i_es_rd             (i_es_rd),
    .i_es_csr_wen        (i_es_csr_wen),
    .i_es_csr            (i_es_csr),
    .i_es_mem_ren        (i_es_mem_ren),
    .i_es_mem_op         (i_es_mem_op),
    .i_es_csr_inst_sel   (i_es_csr_inst_sel),
    .i_es_csrrdata       (i_es_csrrdata),
    .i_es_alu_result     (i_es_alu_result),
    .i_es_csr_result     (i_es_csr_result),
    .o_ms_allowin        (o_ms_allowin),
    .i_data_sram_data_ok (i_data_sram_data_ok),
    .i_data_sram_rdata   (i_data_sram_rdata),
    .ms                  (u_ms_ws_if),
    .o_ms_byp_rd         (o_ms_byp_rd),
    .o_ms_byp_gpr_data   (o_ms_byp_gpr_data),
    .o_ms_byp_csr        (o_ms_byp_csr),
    .o_ms_byp_csr_data   (o_ms_byp_csr_data),
    .o_ms_byp_ready      (o_ms_byp_ready)
  );

  wb_stage u_wb_stage (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_ws_hold      (i_ws_hold),
    .ws             (u_ms_ws_if),
    .i_rf_raddr     (i_rf_raddr),
    .o_rf_rdata     (o_rf_rdata),
    .o_ws_gpr_wen   (o_ws_gpr_wen),
    .o_ws_rd        (o_ws_rd),
    .o_ws_gpr_wdata (o_ws_gpr_wdata),
    .o_ws_csr_wen   (o_ws_csr_wen),
    .o_ws_csr       (o_ws_csr),
    .o_ws_csr_wdata (o_ws_csr_wdata)
  );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps
// testbench checker: models both stages from the port activity and compares every cycle
module tb_checker
  import cpu_params_pkg::*, mem_types_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_es_to_ms_valid,
  input  logic                   i_es_gpr_wen,
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic                   i_es_csr_wen,
  input  logic [CSR_ADDR_WD-1:0] i_es_csr,
  input  logic                   i_es_mem_ren,
  input  mem_op_e                i_es_mem_op,
  input  logic                   i_es_csr_inst_sel,
  input  logic [WORD_WD-1:0]     i_es_csrrdata,
  input  logic [WORD_WD-1:0]     i_es_alu_result,
  input  logic [WORD_WD-1:0]     i_es_csr_result,
  input  logic                   i_ms_allowin,
  input  logic                   i_ms_to_ws_valid,
  input  logic                   i_data_ok,
  input  logic [WORD_WD-1:0]     i_rdata,
  input  logic [GPR_ADDR_WD-1:0] i_byp_rd,
  input  logic [WORD_WD-1:0]     i_byp_gpr_data,
  input  logic [CSR_ADDR_WD-1:0] i_byp_csr,
  input  logic [WORD_WD-1:0]     i_byp_csr_data,
  input  logic                   i_byp_ready,
  input  logic                   i_ws_hold,
  input  logic                   i_ws_gpr_wen,
  input  logic [GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [WORD_WD-1:0]     i_ws_gpr_wdata,
  input  logic                   i_ws_csr_wen,
  input  logic [CSR_ADDR_WD-1:0] i_ws_csr,
  input  logic [WORD_WD-1:0]     i_ws_csr_wdata,
  input  logic [GPR_ADDR_WD-1:0] i_rf_raddr,
  input  logic [WORD_WD-1:0]     i_rf_rdata,
  input  logic                   i_rf_check,
  output int                     o_errors,
  output int                     o_commits,
  output int                     o_pending
);

  typedef struct {
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic                   csr_wen;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   mem_ren;
    mem_op_e                op;
    logic                   sel;
    logic [WORD_WD-1:0]     csrrdata;
    logic [WORD_WD-1:0]     alu;
    logic [WORD_WD-1:0]     csr_result;
    logic                   have_data;
    logic [WORD_WD-1:0]     rdata;
  } entry_t;

  entry_t             q[$];  // q[0] sits in writeback when ws_full, q[$] in memory when ms_full
  logic [WORD_WD-1:0] model_gpr [NUM_GPR];
  logic               ms_full = 1'b0;
  logic               ws_full = 1'b0;
  logic               rst_seen = 1'b0;
  int                 errors = 0;
  int                 commits = 0;
  int                 pending = 0;

  assign o_errors  = errors;
  assign o_commits = commits;
  assign o_pending = pending;

  // shift the addressed lane down, then extend
  function automatic logic [WORD_WD-1:0] load_extend(mem_op_e op, logic [2:0] off,
                                                     logic [WORD_WD-1:0] w);
    logic [WORD_WD-1:0] b;
    logic [WORD_WD-1:0] h;
    logic [WORD_WD-1:0] s;
    b = w >> (8 * off);
    h = w >> (8 * (off & 3'b110));
    s = w >> (8 * (off & 3'b100));
    case (op)
      LB:      return {{56{b[7]}}, b[7:0]};
      LH:      return {{48{h[15]}}, h[15:0]};
      LW:      return {{32{s[31]}}, s[31:0]};
      LBU:     return {56'd0, b[7:0]};
      LHU:     return {48'd0, h[15:0]};
      LWU:     return {32'd0, s[31:0]};
      default: return w;
    endcase
  endfunction

  function automatic logic [WORD_WD-1:0] final_result(entry_t e);
    if (e.mem_ren) return load_extend(e.op, e.alu[2:0], e.rdata);
    if (e.sel) return e.csrrdata;
    return e.alu;
  endfunction

  task automatic check(string name, logic [WORD_WD-1:0] got, logic [WORD_WD-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_rf();
    logic [WORD_WD-1:0] exp;
    exp = (i_rf_raddr == '0) ? '0 : model_gpr[i_rf_raddr];
    check("o_rf_rdata", i_rf_rdata, exp);
  endtask

  always @(posedge i_clk) begin
    entry_t e;
    entry_t c;
    logic   ready;
    logic   ws_allow;
    logic   xfer;
    logic   commit;
    logic   accept;
    logic   byp_on;
    logic   csr_on;
    if (i_rst) begin
      if (rst_seen) begin
        check("o_ws_csr_wen", 64'(i_ws_csr_wen), 64'(1'b0));
        check("o_ms_allowin", 64'(i_ms_allowin), 64'(1'b1));
        check("o_rf_rdata", i_rf_rdata, '0);
      end
      q.delete();
      ms_full = 1'b0;
      ws_full = 1'b0;
      for (int i = 0; i < NUM_GPR; i++) begin
        model_gpr[i] = '0;
      end
      rst_seen = 1'b1;
    end else begin
      if (i_data_ok) begin
        if (ms_full && q[$].mem_ren && !q[$].have_data) begin
          q[$].rdata     = i_rdata;
          q[$].have_data = 1'b1;
        end else begin
          $display("data_ok arrived at %0t with no load waiting", $time);
          errors++;
        end
      end
      ready    = ms_full && (!q[$].mem_ren || q[$].have_data);
      ws_allow = !ws_full || !i_ws_hold;
      commit   = ws_full && !i_ws_hold;
      xfer     = ready && ws_allow;
      accept   = i_es_to_ms_valid && i_ms_allowin;
      check("o_ms_to_ws_valid", 64'(i_ms_to_ws_valid), 64'(ready));
      check("o_ms_allowin", 64'(i_ms_allowin), 64'(!ms_full || xfer));

      // bypass masking
      byp_on = ms_full && q[$].gpr_wen;
      csr_on = ms_full && q[$].csr_wen;
      check("o_ms_byp_ready", 64'(i_byp_ready), 64'(byp_on && ready));
      check("o_ms_byp_rd", 64'(i_byp_rd), byp_on ? 64'(q[$].rd) : '0);
      if (!byp_on) check("o_ms_byp_gpr_data", i_byp_gpr_data, '0);
      else if (ready) check("o_ms_byp_gpr_data", i_byp_gpr_data, final_result(q[$]));
      check("o_ms_byp_csr", 64'(i_byp_csr), csr_on ? 64'(q[$].csr) : '0);
      check("o_ms_byp_csr_data", i_byp_csr_data, csr_on ? q[$].csr_result : '0);

      if (i_rf_check) check_rf();

      if (commit) begin
        c = q.pop_front();
        commits++;
        check("o_ws_gpr_wen", 64'(i_ws_gpr_wen), 64'(c.gpr_wen));
        check("o_ws_csr_wen", 64'(i_ws_csr_wen), 64'(c.csr_wen));
        if (c.gpr_wen) begin
          check("o_ws_rd", 64'(i_ws_rd), 64'(c.rd));
          check("o_ws_gpr_wdata", i_ws_gpr_wdata, final_result(c));
          if (c.rd != '0) model_gpr[c.rd] = final_result(c);
        end
        if (c.csr_wen) begin
          check("o_ws_csr", 64'(i_ws_csr), 64'(c.csr));
          check("o_ws_csr_wdata", i_ws_csr_wdata, c.csr_result);
        end
      end else begin
        check("o_ws_gpr_wen", 64'(i_ws_gpr_wen), 64'(1'b0));
        check("o_ws_csr_wen", 64'(i_ws_csr_wen), 64'(1'b0));
      end

      if (accept) begin
        e.gpr_wen    = i_es_gpr_wen;
        e.rd         = i_es_rd;
        e.csr_wen    = i_es_csr_wen;
        e.csr        = i_es_csr;
        e.mem_ren    = i_es_mem_ren;
        e.op         = i_es_mem_op;
        e.sel        = i_es_csr_inst_sel;
        e.csrrdata   = i_es_csrrdata;
        e.alu        = i_es_alu_result;
        e.csr_result = i_es_csr_result;
        e.have_data  = 1'b0;
        e.rdata      = '0;
        q.push_back(e);
      end
      ws_full = xfer ? 1'b1 : (commit ? 1'b0 : ws_full);
      ms_full = accept ? 1'b1 : (xfer ? 1'b0 : ms_full);
      rst_seen = 1'b0;
    end
    pending = q.size();
  end

endmodule

//--- tb_mem_wb.sv
`timescale 1ns/1ps
// testbench top that drives random execute and sram traffic into mem_wb_top beside the checker
module tb_mem_wb
  import cpu_params_pkg::*, mem_types_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic                   clk = 1'b0;
  logic                   rst = 1'b1;
  logic                   es_valid = 1'b0;
  logic                   es_gpr_wen = 1'b0;
  logic [GPR_ADDR_WD-1:0] es_rd = '0;
  logic                   es_csr_wen = 1'b0;
  logic [CSR_ADDR_WD-1:0] es_csr = '0;
  logic                   es_mem_ren = 1'b0;
  mem_op_e                es_mem_op = LB;
  logic                   es_sel = 1'b0;
  logic [WORD_WD-1:0]     es_csrrdata = '0;
  logic [WORD_WD-1:0]     es_alu = '0;
  logic [WORD_WD-1:0]     es_csr_result = '0;
  logic                   data_ok = 1'b0;
  logic [WORD_WD-1:0]     rdata = '0;
  logic                   ws_hold = 1'b0;
  logic [GPR_ADDR_WD-1:0] rf_raddr = '0;
  logic                   rf_check = 1'b0;
  logic                   hold_en = 1'b0;
  int                     hold_left = 0;
  logic                   timed_out = 1'b0;
  int                     tests = 0;

  logic                   ms_allowin, ms_to_ws_valid, byp_ready;
  logic [GPR_ADDR_WD-1:0] byp_rd, ws_rd;
  logic [WORD_WD-1:0]     byp_gpr_data, byp_csr_data, rf_rdata, ws_gpr_wdata, ws_csr_wdata;
  logic [CSR_ADDR_WD-1:0] byp_csr, ws_csr;
  logic                   ws_gpr_wen, ws_csr_wen;
  int                     errors, commits, pending;

  always #10 clk = ~clk;

  mem_wb_top i_mem_wb_top (
    .i_clk (clk), .i_rst (rst),
    .i_es_to_ms_valid (es_valid), .i_es_gpr_wen (es_gpr_wen), .i_es_rd (es_rd),
    .i_es_csr_wen (es_csr_wen), .i_es_csr (es_csr), .i_es_mem_ren (es_mem_ren),
    .i_es_mem_op (es_mem_op), .i_es_csr_inst_sel (es_sel), .i_es_csrrdata (es_csrrdata),
    .i_es_alu_result (es_alu), .i_es_csr_result (es_csr_result),
    .o_ms_allowin (ms_allowin), .o_ms_to_ws_valid (ms_to_ws_valid),
    .i_data_sram_data_ok (data_ok), .i_data_sram_rdata (rdata),
    .o_ms_byp_rd (byp_rd), .o_ms_byp_gpr_data (byp_gpr_data), .o_ms_byp_csr (byp_csr),
    .o_ms_byp_csr_data (byp_csr_data), .o_ms_byp_ready (byp_ready),
    .i_rf_raddr (rf_raddr), .o_rf_rdata (rf_rdata), .i_ws_hold (ws_hold),
    .o_ws_gpr_wen (ws_gpr_wen), .o_ws_rd (ws_rd), .o_ws_gpr_wdata (ws_gpr_wdata),
    .o_ws_csr_wen (ws_csr_wen), .o_ws_csr (ws_csr), .o_ws_csr_wdata (ws_csr_wdata)
  );

  tb_checker u_checker (
    .i_clk (clk), .i_rst (rst),
    .i_es_to_ms_valid (es_valid), .i_es_gpr_wen (es_gpr_wen), .i_es_rd (es_rd),
    .i_es_csr_wen (es_csr_wen), .i_es_csr (es_csr), .i_es_mem_ren (es_mem_ren),
    .i_es_mem_op (es_mem_op), .i_es_csr_inst_sel (es_sel), .i_es_csrrdata (es_csrrdata),
    .i_es_alu_result (es_alu), .i_es_csr_result (es_csr_result),
    .i_ms_allowin (ms_allowin), .i_ms_to_ws_valid (ms_to_ws_valid),
    .i_data_ok (data_ok), .i_rdata (rdata), .i_byp_rd (byp_rd),
    .i_byp_gpr_data (byp_gpr_data), .i_byp_csr (byp_csr), .i_byp_csr_data (byp_csr_data),
    .i_byp_ready (byp_ready), .i_ws_hold (ws_hold), .i_ws_gpr_wen (ws_gpr_wen),
    .i_ws_rd (ws_rd), .i_ws_gpr_wdata (ws_gpr_wdata), .i_ws_csr_wen (ws_csr_wen),
    .i_ws_csr (ws_csr), .i_ws_csr_wdata (ws_csr_wdata), .i_rf_raddr (rf_raddr),
    .i_rf_rdata (rf_rdata), .i_rf_check (rf_check),
    .o_errors (errors), .o_commits (commits), .o_pending (pending)
  );

  // writeback stall bursts
  always @(negedge clk) begin
    if (!hold_en) begin
      ws_hold = 1'b0;
      hold_left = 0;
    end else if (hold_left > 0) begin
      hold_left--;
      if (hold_left == 0) ws_hold = 1'b0;
    end else if ($urandom % 6 == 0) begin
      ws_hold = 1'b1;
      hold_left = 1 + $urandom % 5;
    end
  end

  // one bundle; a load also gets its data_ok pulse after a random delay
  task automatic issue(logic load, mem_op_e op, logic [2:0] off);
    int waited;
    int delay;
    waited = 0;
    delay = $urandom % 7;
    if (timed_out) return;
    @(negedge clk);
    es_valid      = 1'b1;
    es_mem_ren    = load;
    es_mem_op     = op;
    es_gpr_wen    = load ? 1'b1 : ($urandom % 5 != 0);
    es_rd         = 5'($urandom);
    es_csr_wen    = ($urandom % 10 < 3);
    es_csr        = 12'($urandom);
    es_sel        = 1'($urandom);
    es_csrrdata   = {$urandom, $urandom};
    es_alu        = {$urandom, $urandom};
    es_alu[2:0]   = off;
    es_csr_result = {$urandom, $urandom};
    forever begin
      @(posedge clk);
      if (ms_allowin) break;
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: memory stage never accepted a bundle at %0t", $time);
        timed_out = 1'b1;
        break;
      end
    end
    if (load && !timed_out) begin
      @(negedge clk);
      es_valid = 1'b0;
      repeat (delay) @(negedge clk);
      data_ok = 1'b1;
      rdata   = {$urandom, $urandom};
      @(negedge clk);
      data_ok = 1'b0;
      rdata   = {$urandom, $urandom};  // bus carries junk outside the pulse
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    es_valid = 1'b0;
    hold_en  = 1'b0;
    while (pending != 0 && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: %0d instructions never committed", pending);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic end_test(string name);
    tests++;
    $display("test %s finished at %0t, %0d errors so far", name, $time, errors);
  endtask

  initial begin
    void'($urandom(19));
    repeat (2) begin
      @(negedge clk);
      rf_raddr = 5'($urandom);
    end
    rst = 1'b0;
    @(negedge clk);
    end_test("reset_state");

    // every op at every offset
    for (int op = 0; op < 7; op++) begin
      for (int off = 0; off < 8; off++) begin
        issue(1'b1, mem_op_e'(op), 3'(off));
      end
    end
    drain();
    end_test("load_format");

    hold_en = 1'b1;
    for (int n = 0; n < 400 && !timed_out; n++) begin
      issue(($urandom % 10 < 4), mem_op_e'($urandom % 7), 3'($urandom));
      if ($urandom % 4 == 0) begin
        @(negedge clk);
        es_valid = 1'b0;
      end
    end
    drain();
    end_test("random_backpressure");

    for (int a = 0; a < NUM_GPR; a++) begin
      @(negedge clk);
      rf_check = 1'b1;
      rf_raddr = 5'(a);
    end
    @(negedge clk);
    rf_check = 1'b0;
    end_test("register_file");

    $display("tests=%0d commits=%0d errors=%0d timeout=%0d", tests, commits, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
cpu_params_pkg.sv
mem_types_pkg.sv
ms_ws_if.sv
lsu_load.sv
mem_stage.sv
wb_stage.sv
mem_wb_top.sv
tb_checker.sv
tb_mem_wb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mem_wb -f verilog.f \
  -o sim_mem_wb > build.log 2>&1 \
  && ./obj_dir/sim_mem_wb > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0
